// File: all.f
source/lc3b_pkg.sv
source/issue_control.sv
source/reg_status.sv
source/rob.sv
source/alu_stations.sv
source/tomasulo_core.sv
verif/tomasulo_sva.sv
verif/tomasulo_tb.sv

// File: run.sh
#!/bin/sh
# Build with Verilator, run, and pass only if the testbench reports success
verilator --binary --timing --timescale 1ns/100ps --top-module tomasulo_tb -f all.f \
	-o tomasulo_sim && ./obj_dir/tomasulo_sim | tee /dev/stderr | grep -q "Test passed" || exit 1

// File: verif/tomasulo_tb.sv
module tomasulo_tb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int STALL_LIMIT = 50;
	localparam int DRAIN_LIMIT = 200;

	// One row of the stimulus table
	typedef struct packed {
		lc3b_pkg::lc3b_word instr;
		logic               commits;
		lc3b_pkg::commit_t  exp;
	} stim_t;

	logic clk;
	logic arst_n;
	lc3b_pkg::lc3b_word instr;
	logic instr_is_new;
	logic stall;
	logic commit_valid;
	lc3b_pkg::commit_t commit;

	stim_t stim_q[$];
	lc3b_pkg::commit_t expected_q[$]; // Issued, not yet retired
	int value_errors = 0;
	int other_errors = 0;
	integer seed = 32'h724cbe75;

	tomasulo_core dut0
	(
		.clk, .arst_n, .instr, .instr_is_new, .stall, .commit_valid, .commit
	);

	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	task automatic add_alu(input lc3b_pkg::lc3b_word w, input lc3b_pkg::lc3b_reg dest,
		input lc3b_pkg::lc3b_word value);
		stim_q.push_back('{instr: w, commits: 1'b1, exp: '{dest: dest, value: value}});
	endtask

	task automatic add_dropped(input lc3b_pkg::lc3b_word w);
		stim_q.push_back('{instr: w, commits: 1'b0, exp: '0});
	endtask

	task automatic build_table();
		logic [4:0] imm;
		lc3b_pkg::lc3b_reg dest;
		lc3b_pkg::lc3b_word value;
		add_alu(16'h1226, 3'd1, 16'h0006); // ADD R1, R0, #6
		add_alu(16'h143D, 3'd2, 16'hFFFD); // ADD R2, R0, #-3
		add_alu(16'h56BE, 3'd3, 16'hFFFC); // AND R3, R2, #-2
		// Dependent register-form chain
		add_alu(16'h1842, 3'd4, 16'h0003); // ADD R4, R1, R2
		add_alu(16'h5B01, 3'd5, 16'h0002); // AND R5, R4, R1
		add_alu(16'h9D7F, 3'd6, 16'hFFFD); // NOT R6, R5
		add_alu(16'h1F83, 3'd7, 16'hFFF9); // ADD R7, R6, R3
		add_alu(16'h1247, 3'd1, 16'hFFFF); // ADD R1, R1, R7 renames R1
		add_dropped(16'h0E05);             // BR
		add_alu(16'h5446, 3'd2, 16'hFFFD); // AND R2, R1, R6
		add_dropped(16'hF025);             // TRAP
		add_alu(16'h96BF, 3'd3, 16'h0002); // NOT R3, R2
		add_alu(16'h18FF, 3'd4, 16'h0001); // ADD R4, R3, #-1
		// Burst of independent immediate adds from R0
		for (int k = 0; k < 10; k++)
		begin
			imm = 5'($random(seed));
			dest = 3'(1 + k % 7);
			value = 16'(imm);
			if (imm[4])
				value = value - 16'd32; // imm5 spans -16 to 15
			add_alu({4'b0001, dest, 3'b000, 1'b1, imm}, dest, value);
		end
	endtask

	task automatic check_commit(input lc3b_pkg::commit_t got, input lc3b_pkg::commit_t exp);
		if (got !== exp)
		begin
			value_errors++;
			$display("** Error at %0t ns: commit R%0d = %h, expected R%0d = %h",
				$time, got.dest, got.value, exp.dest, exp.value);
		end
	endtask

	task automatic check_stall(input logic got, input logic exp);
		if (got !== exp)
		begin
			value_errors++;
			$display("** Error at %0t ns: stall = %b, expected %b", $time, got, exp);
		end
	endtask

	// Holds the word until the core takes it
	task automatic present(input stim_t s, inout logic ok);
		int waited;
		instr = s.instr;
		instr_is_new = 1'b1;
		waited = 0;
		@(negedge clk);
		while (stall && ok)
		begin
			if (waited == STALL_LIMIT)
			begin
				other_errors++;
				$display("Stall stayed high too long on instruction %h", s.instr);
				ok = 1'b0;
			end
			else
			begin
				waited++;
				@(negedge clk);
			end
		end
		if (ok)
		begin
			@(posedge clk);
			#1;
			if (s.commits)
				expected_q.push_back(s.exp);
		end
		instr_is_new = 1'b0;
	endtask

	// Commit port, sampled mid-cycle
	always @(negedge clk)
	begin
		if (commit_valid === 1'b1)
		begin
			if (expected_q.size() == 0)
			begin
				other_errors++;
				$display("Commit to R%0d at %0t ns with no instruction outstanding",
					commit.dest, $time);
			end
			else
				check_commit(commit, expected_q.pop_front());
		end
	end

	initial
	begin
		int waited;
		logic ok;
		arst_n = 1'b0;
		instr = '0;
		instr_is_new = 1'b0;
		build_table();
		repeat (5) @(posedge clk);
		#1 arst_n = 1'b1;
		// Idle, no commit expected
		for (int c = 0; c < 3; c++)
		begin
			@(negedge clk);
			check_stall(stall, 1'b1); // Nothing offered yet
		end
		@(posedge clk);
		#1;
		ok = 1'b1;
		foreach (stim_q[i])
			if (ok)
				present(stim_q[i], ok);
		waited = 0;
		while (ok && expected_q.size() != 0)
		begin
			@(negedge clk);
			waited++;
			if (waited > DRAIN_LIMIT)
			begin
				other_errors++;
				$display("Timed out with %0d commits still missing", expected_q.size());
				ok = 1'b0;
			end
		end
		repeat (8) @(negedge clk); // Catch stray commits
		$display("Summary: %0d value errors, %0d other errors", value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule: tomasulo_tb

// File: verif/tomasulo_sva.sv
module tomasulo_sva
(
	input logic                                        clk,
	input logic                                        arst_n,
	input logic                                        commit_valid,
	input logic                                        stall,
	input logic                                        issue_valid,
	input logic [lc3b_pkg::NUM_STATIONS-1:0]           station_busy,
	input logic [1:0]                                  res_station_id,
	input logic [$clog2(lc3b_pkg::ROB_DEPTH+1)-1:0]    rob_count,
	input lc3b_pkg::station_entry_t                    st [lc3b_pkg::NUM_STATIONS]
);
	timeunit 1ns;
	timeprecision 100ps;

	logic tag_clash;

	// Two live stations on one ROB tag
	always_comb
	begin
		tag_clash = 1'b0;
		for (int i = 0; i < lc3b_pkg::NUM_STATIONS; i++)
			for (int j = i + 1; j < lc3b_pkg::NUM_STATIONS; j++)
				if (st[i].busy && st[j].busy && st[i].dest == st[j].dest)
					tag_clash = 1'b1;
	end

	commit_needs_entry: assert property (@(posedge clk) disable iff (!arst_n)
		commit_valid |-> rob_count != '0)
		else $error("commit_valid with an empty ROB");

	// Target station must be free as well
	no_issue_in_stall: assert property (@(posedge clk) disable iff (!arst_n)
		issue_valid |-> !stall && !station_busy[res_station_id])
		else $error("Issue while stall is high or into a busy station");

	unique_station_dest: assert property (@(posedge clk) disable iff (!arst_n) !tag_clash)
		else $error("Busy stations share a dest tag");

endmodule: tomasulo_sva

bind tomasulo_core tomasulo_sva sva0
(
	.clk, .arst_n, .commit_valid, .stall, .issue_valid, .station_busy, .res_station_id,
	.rob_count(rob0.count), .st(stations0.st)
);

// File: source/tomasulo_core.sv
module tomasulo_core
(
	input  logic               clk,
	input  logic               arst_n,
	input  lc3b_pkg::lc3b_word instr,
	input  logic               instr_is_new,
	output logic               stall,
	output logic               commit_valid,
	output lc3b_pkg::commit_t  commit
);

lc3b_pkg::cdb_t cdb;
lc3b_pkg::station_entry_t issue_entry;
lc3b_pkg::rob_alloc_t rob_alloc;
lc3b_pkg::reg_entry_t sr1_in;
lc3b_pkg::reg_entry_t sr2_in;
lc3b_pkg::lc3b_reg sr1;
lc3b_pkg::lc3b_reg sr2;
lc3b_pkg::lc3b_reg reg_dest;
lc3b_pkg::lc3b_rob_addr rob_addr;
lc3b_pkg::lc3b_rob_addr rob_sr1_read_addr;
lc3b_pkg::lc3b_rob_addr rob_sr2_read_addr;
lc3b_pkg::lc3b_rob_addr commit_tag;
lc3b_pkg::lc3b_word rob_sr1_value_out;
lc3b_pkg::lc3b_word rob_sr2_value_out;
logic [lc3b_pkg::NUM_STATIONS-1:0] station_busy;
logic [1:0] res_station_id;
logic issue_valid;
logic rob_full;
logic rob_write_enable;
logic rob_sr1_valid_out;
logic rob_sr2_valid_out;
logic ld_reg_busy_dest;

issue_control issue0 (.*);

reg_status regs0
(
	.clk, .arst_n, .sr1, .sr2, .sr1_in, .sr2_in, .reg_dest, .ld_reg_busy_dest,
	.issue_tag(rob_addr), .commit_valid, .commit, .commit_tag
);

rob rob0 (.*);

alu_stations stations0 (.*);

endmodule: tomasulo_core

// File: source/alu_stations.sv
module alu_stations
(
	input  logic                     clk,
	input  logic                     arst_n,
	// From issue
	input  logic                     issue_valid,
	input  lc3b_pkg::station_entry_t issue_entry,
	input  logic [1:0]               res_station_id,
	output logic [lc3b_pkg::NUM_STATIONS-1:0] station_busy,
	// Sole CDB driver
	output lc3b_pkg::cdb_t           cdb
);

lc3b_pkg::station_entry_t st [lc3b_pkg::NUM_STATIONS];
logic [1:0] sel;
logic found;
lc3b_pkg::lc3b_word result;

always_comb
begin
	for (int i = 0; i < lc3b_pkg::NUM_STATIONS; i++)
		station_busy[i] = st[i].busy;
end

// Fixed priority, lowest index wins
always_comb
begin
	sel = '0;
	found = 1'b0;
	for (int i = 0; i < lc3b_pkg::NUM_STATIONS; i++)
	begin
		if (!found && st[i].busy && st[i].rdy_j && st[i].rdy_k)
		begin
			sel = 2'(i);
			found = 1'b1;
		end
	end
end

always_comb
begin
	case (st[sel].op)
		lc3b_pkg::op_add: result = st[sel].vj + st[sel].vk;
		lc3b_pkg::op_and: result = st[sel].vj & st[sel].vk;
		lc3b_pkg::op_not: result = ~st[sel].vj;
		default:          result = '0;
	endcase
end

assign cdb = '{valid: found, tag: st[sel].dest, data: result};

always_ff @(posedge clk or negedge arst_n)
begin
	if (!arst_n)
	begin
		for (int i = 0; i < lc3b_pkg::NUM_STATIONS; i++)
			st[i] <= '0;
	end
	else
	begin
		for (int i = 0; i < lc3b_pkg::NUM_STATIONS; i++)
		begin
			if (cdb.valid && sel == 2'(i))
				st[i].busy <= 1'b0; // Result broadcast this cycle
			// Snoop for pending operands
			if (st[i].busy && !st[i].rdy_j && cdb.valid && cdb.tag == st[i].qj)
			begin
				st[i].vj <= cdb.data;
				st[i].rdy_j <= 1'b1;
			end
			if (st[i].busy && !st[i].rdy_k && cdb.valid && cdb.tag == st[i].qk)
			begin
				st[i].vk <= cdb.data;
				st[i].rdy_k <= 1'b1;
			end
			if (issue_valid && res_station_id == 2'(i))
				st[i] <= issue_entry; // Always a free station
		end
	end
end

endmodule: alu_stations

// File: source/rob.sv
module rob
(
	input  logic                   clk,
	input  logic                   arst_n,
	// Allocation at issue
	input  logic                   rob_write_enable,
	input  lc3b_pkg::rob_alloc_t   rob_alloc,
	output logic                   rob_full,
	output lc3b_pkg::lc3b_rob_addr rob_addr,
	// Result capture
	input  lc3b_pkg::cdb_t         cdb,
	// Operand lookup
	input  lc3b_pkg::lc3b_rob_addr rob_sr1_read_addr,
	input  lc3b_pkg::lc3b_rob_addr rob_sr2_read_addr,
	output logic                   rob_sr1_valid_out,
	output logic                   rob_sr2_valid_out,
	output lc3b_pkg::lc3b_word     rob_sr1_value_out,
	output lc3b_pkg::lc3b_word     rob_sr2_value_out,
	// Retirement
	output logic                   commit_valid,
	output lc3b_pkg::commit_t      commit,
	output lc3b_pkg::lc3b_rob_addr commit_tag
);

lc3b_pkg::lc3b_opcode ent_op [lc3b_pkg::ROB_DEPTH];
lc3b_pkg::lc3b_reg ent_dest [lc3b_pkg::ROB_DEPTH];
lc3b_pkg::lc3b_word ent_value [lc3b_pkg::ROB_DEPTH];
logic [lc3b_pkg::ROB_DEPTH-1:0] ent_done;

lc3b_pkg::lc3b_rob_addr head;
lc3b_pkg::lc3b_rob_addr tail;
logic [$clog2(lc3b_pkg::ROB_DEPTH+1)-1:0] count;
logic retire;
logic writes_reg;

assign rob_full = (count == lc3b_pkg::ROB_DEPTH);
assign rob_addr = tail;

assign rob_sr1_valid_out = ent_done[rob_sr1_read_addr];
assign rob_sr2_valid_out = ent_done[rob_sr2_read_addr];
assign rob_sr1_value_out = ent_value[rob_sr1_read_addr];
assign rob_sr2_value_out = ent_value[rob_sr2_read_addr];

assign retire = ent_done[head]; // Free entries keep done clear
// Ops that write a register report on the commit port
assign writes_reg = (ent_op[head] == lc3b_pkg::op_add) ||
	(ent_op[head] == lc3b_pkg::op_and) || (ent_op[head] == lc3b_pkg::op_not);

assign commit_valid = retire && writes_reg;
assign commit = '{dest: ent_dest[head], value: ent_value[head]};
assign commit_tag = head;

// Entry payload
always_ff @(posedge clk)
begin
	if (cdb.valid)
		ent_value[cdb.tag] <= cdb.data;
	if (rob_write_enable)
	begin
		ent_op[tail] <= rob_alloc.opcode;
		ent_dest[tail] <= rob_alloc.dest;
	end
end

always_ff @(posedge clk or negedge arst_n)
begin
	if (!arst_n)
	begin
		head <= '0;
		tail <= '0;
		count <= '0;
		ent_done <= '0;
	end
	else
	begin
		if (cdb.valid)
			ent_done[cdb.tag] <= 1'b1;
		if (retire)
		begin
			ent_done[head] <= 1'b0;
			head <= head + 1'b1; // Depth of 8 wraps on its own
		end
		if (rob_write_enable)
		begin
			ent_done[tail] <= 1'b0;
			tail <= tail + 1'b1;
		end
		case ({rob_write_enable, retire})
			2'b10: count <= count + 1'b1;
			2'b01: count <= count - 1'b1;
			default: ; // Both or neither
		endcase
	end
end

endmodule: rob

// File: source/reg_status.sv
module reg_status
(
	input  logic                   clk,
	input  logic                   arst_n,
	// Source reads
	input  lc3b_pkg::lc3b_reg      sr1,
	input  lc3b_pkg::lc3b_reg      sr2,
	output lc3b_pkg::reg_entry_t   sr1_in,
	output lc3b_pkg::reg_entry_t   sr2_in,
	// Issue marking
	input  lc3b_pkg::lc3b_reg      reg_dest,
	input  logic                   ld_reg_busy_dest,
	input  lc3b_pkg::lc3b_rob_addr issue_tag,
	// Retirement
	input  logic                   commit_valid,
	input  lc3b_pkg::commit_t      commit,
	input  lc3b_pkg::lc3b_rob_addr commit_tag
);

lc3b_pkg::reg_entry_t regs [8];

assign sr1_in = regs[sr1];
assign sr2_in = regs[sr2];

always_ff @(posedge clk or negedge arst_n)
begin
	if (!arst_n)
	begin
		for (int i = 0; i < 8; i++)
			regs[i] <= '0;
	end
	else
	begin
		if (commit_valid)
		begin
			regs[commit.dest].data <= commit.value;
			// Only the latest producer frees the register
			if (regs[commit.dest].rob_entry == commit_tag)
				regs[commit.dest].busy <= 1'b0;
		end
		// Later assignment, so an issue overrides a same-cycle clear
		if (ld_reg_busy_dest)
		begin
			regs[reg_dest].busy <= 1'b1;
			regs[reg_dest].rob_entry <= issue_tag;
		end
	end
end

endmodule: reg_status

// File: source/issue_control.sv
module issue_control
(
	input  logic                     clk,
	// Fetch side
	input  lc3b_pkg::lc3b_word       instr,
	input  logic                     instr_is_new,
	output logic                     stall,
	// Common data bus
	input  lc3b_pkg::cdb_t           cdb,
	// Reservation stations
	input  logic [lc3b_pkg::NUM_STATIONS-1:0] station_busy,
	output logic                     issue_valid,
	output lc3b_pkg::station_entry_t issue_entry,
	output logic [1:0]               res_station_id,
	// ROB
	input  logic                     rob_full,
	input  lc3b_pkg::lc3b_rob_addr   rob_addr,
	input  logic                     rob_sr1_valid_out,
	input  logic                     rob_sr2_valid_out,
	input  lc3b_pkg::lc3b_word       rob_sr1_value_out,
	input  lc3b_pkg::lc3b_word       rob_sr2_value_out,
	output logic                     rob_write_enable,
	output lc3b_pkg::rob_alloc_t     rob_alloc,
	output lc3b_pkg::lc3b_rob_addr   rob_sr1_read_addr,
	output lc3b_pkg::lc3b_rob_addr   rob_sr2_read_addr,
	// Register status
	input  lc3b_pkg::reg_entry_t     sr1_in,
	input  lc3b_pkg::reg_entry_t     sr2_in,
	output lc3b_pkg::lc3b_reg        sr1,
	output lc3b_pkg::lc3b_reg        sr2,
	output lc3b_pkg::lc3b_reg        reg_dest,
	output logic                     ld_reg_busy_dest
);

lc3b_pkg::lc3b_opcode opcode;
lc3b_pkg::lc3b_word sext5;
logic alu_op;
logic accept;

assign opcode = lc3b_pkg::lc3b_opcode'(instr[15:12]);
assign sext5 = {{11{instr[4]}}, instr[4:0]};
assign alu_op = (opcode == lc3b_pkg::op_add) || (opcode == lc3b_pkg::op_and) ||
	(opcode == lc3b_pkg::op_not);

assign sr1 = instr[8:6];
assign sr2 = instr[2:0];
assign reg_dest = instr[11:9];

// Producer entries of the sources
assign rob_sr1_read_addr = sr1_in.rob_entry;
assign rob_sr2_read_addr = sr2_in.rob_entry;

assign stall = !instr_is_new || rob_full || (alu_op && (&station_busy));
assign accept = !stall && alu_op; // Other opcodes are dropped

assign issue_valid = accept;
assign rob_write_enable = accept;
assign ld_reg_busy_dest = accept;
assign rob_alloc = '{opcode: opcode, dest: instr[11:9]};

// Register file, then CDB, then ROB, else wait on the tag
function automatic void resolve
(
	input  lc3b_pkg::reg_entry_t   r,
	input  lc3b_pkg::cdb_t         bus,
	input  logic                   rob_valid,
	input  lc3b_pkg::lc3b_word     rob_value,
	output lc3b_pkg::lc3b_word     v,
	output lc3b_pkg::lc3b_rob_addr q,
	output logic                   rdy
);
	v = r.data;
	q = r.rob_entry;
	rdy = 1'b1;
	if (r.busy)
	begin
		if (bus.valid && bus.tag == r.rob_entry)
			v = bus.data;
		else if (rob_valid)
			v = rob_value;
		else
			rdy = 1'b0;
	end
endfunction

always_comb
begin
	issue_entry = '0;
	issue_entry.op = opcode;
	issue_entry.dest = rob_addr;
	issue_entry.busy = 1'b1;

	resolve(sr1_in, cdb, rob_sr1_valid_out, rob_sr1_value_out,
		issue_entry.vj, issue_entry.qj, issue_entry.rdy_j);

	if (opcode == lc3b_pkg::op_not)
		issue_entry.rdy_k = 1'b1; // Unary op
	else if (instr[5])
	begin
		issue_entry.vk = sext5; // imm5 form
		issue_entry.rdy_k = 1'b1;
	end
	else
		resolve(sr2_in, cdb, rob_sr2_valid_out, rob_sr2_value_out,
			issue_entry.vk, issue_entry.qk, issue_entry.rdy_k);
end

// Lowest-numbered free station
always_comb
begin
	res_station_id = '0;
	for (int i = lc3b_pkg::NUM_STATIONS - 1; i >= 0; i--)
		if (!station_busy[i])
			res_station_id = 2'(i);
end

endmodule: issue_control

// File: source/lc3b_pkg.sv
package lc3b_pkg;

	// Core sizing
	localparam int unsigned ROB_DEPTH    = 8;
	localparam int unsigned NUM_STATIONS = 3;

	typedef logic [15:0] lc3b_word;
	typedef logic [2:0]  lc3b_reg;
	typedef logic [2:0]  lc3b_rob_addr; // Also the CDB tag

	// LC-3b opcode field, instr[15:12]
	typedef enum logic [3:0] {
		op_br   = 4'b0000,
		op_add  = 4'b0001,
		op_ldb  = 4'b0010,
		op_stb  = 4'b0011,
		op_jsr  = 4'b0100,
		op_and  = 4'b0101,
		op_ldr  = 4'b0110,
		op_str  = 4'b0111,
		op_rti  = 4'b1000,
		op_not  = 4'b1001, // Shares encoding with XOR
		op_ldi  = 4'b1010,
		op_sti  = 4'b1011,
		op_jmp  = 4'b1100,
		op_shf  = 4'b1101,
		op_lea  = 4'b1110,
		op_trap = 4'b1111
	} lc3b_opcode;

	// Register status as seen by issue
	typedef struct packed {
		logic         busy;
		lc3b_rob_addr rob_entry;
		lc3b_word     data;
	} reg_entry_t;

	typedef struct packed {
		logic         valid;
		lc3b_rob_addr tag;
		lc3b_word     data;
	} cdb_t;

	// One reservation station, also the issue packet
	typedef struct packed {
		lc3b_opcode   op;
		lc3b_word     vj;
		lc3b_word     vk;
		lc3b_rob_addr qj;
		lc3b_rob_addr qk;
		logic         rdy_j;
		logic         rdy_k;
		lc3b_rob_addr dest;
		logic         busy;
	} station_entry_t;

	typedef struct packed {
		lc3b_opcode opcode;
		lc3b_reg    dest;
	} rob_alloc_t;

	// Retirement record
	typedef struct packed {
		lc3b_reg  dest;
		lc3b_word value;
	} commit_t;

endpackage
